//--- vlog.f
logic/cpu_pkg.sv
logic/ctrl_if.sv
logic/inst_fetch.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/data_mem.sv
logic/cpu_top.sv
verif/cpu_tb.sv

//--- verif/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] reset_pc   = 32'h8000_0000;
    localparam int          prog_len   = 48;
    localparam int          max_cycles = prog_len * 2 + 20;

    logic        clk;
    logic        rst_n;
    logic        imem_we;
    logic [7:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic [31:0] pc;
    logic [31:0] dnpc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        halt;
    logic [31:0] a0_value;

    // Kinds: 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SLT 6 ADDI 7 LUI 8 AUIPC
    // 9 JAL 10 BEQ 11 BNE 12 LW 13 SW 14 EBREAK
    int          kind_q [prog_len];
    logic [4:0]  rd_q   [prog_len];
    logic [4:0]  rs1_q  [prog_len];
    logic [4:0]  rs2_q  [prog_len];
    logic [31:0] imm_q  [prog_len];
    logic [31:0] word_q [prog_len];
    logic [31:0] mregs  [32];                          // Model state
    logic [31:0] mdmem  [256];
    logic [31:0] mpc;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycles = 0;

    cpu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:16]);
    endfunction

    function automatic logic [31:0] encode(int k, logic [4:0] rd, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [31:0] imm);
        case (k)
            0:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            1:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            2:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            3:  return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            4:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            5:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
            6:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            7:  return {imm[31:12], rd, 7'b0110111};
            8:  return {imm[31:12], rd, 7'b0010111};
            9:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            10: return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            11: return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            12: return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            13: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            default: return 32'h0010_0073;             // EBREAK
        endcase
    endfunction

    task automatic make_program();
        int lim;
        for (int i = 0; i < prog_len; i++) begin
            kind_q[i] = (i == 0) ? 6 : (i == prog_len - 1) ? 14 : next_rand() % 14;
            rd_q[i]   = (i == 0) ? 5'(1 + next_rand() % 15) : 5'(next_rand() % 16);
            rs1_q[i]  = (i == 0) ? 5'd0 : 5'(next_rand() % 16);
            rs2_q[i]  = 5'(next_rand() % 16);
            lim       = (prog_len - 1 - i < 6) ? prog_len - 1 - i : 6;
            case (kind_q[i])
                6:         imm_q[i] = 32'(next_rand() % 128 - 64);   // Small signed
                7, 8:      imm_q[i] = 32'(((next_rand() << 15) | next_rand()) << 12);
                9, 10, 11: imm_q[i] = 32'(4 * (1 + next_rand() % lim));  // Forward only
                12, 13: begin
                    rs1_q[i] = 5'd0;
                    imm_q[i] = 32'(4 * (next_rand() % 16));   // Few words so loads hit stores
                end
                default:   imm_q[i] = '0;
            endcase
            word_q[i] = encode(kind_q[i], rd_q[i], rs1_q[i], rs2_q[i], imm_q[i]);
        end
    endtask

    task automatic expect_value(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_step(output bit stopped);
        int          idx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] val;
        logic [31:0] npc;
        bit          wr;
        idx     = int'((mpc - reset_pc) >> 2);
        a       = mregs[rs1_q[idx]];
        b       = mregs[rs2_q[idx]];
        ea      = a + imm_q[idx];
        val     = '0;
        npc     = mpc + 32'd4;
        wr      = 1'b1;
        stopped = 1'b0;
        case (kind_q[idx])
            0:  val = a + b;
            1:  val = a - b;
            2:  val = a & b;
            3:  val = a | b;
            4:  val = a ^ b;
            5:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:  val = a + imm_q[idx];
            7:  val = imm_q[idx];
            8:  val = mpc + imm_q[idx];
            9: begin
                val = mpc + 32'd4;                     // Link address
                npc = mpc + imm_q[idx];
            end
            10, 11: begin
                wr = 1'b0;
                if ((a == b) == (kind_q[idx] == 10)) npc = mpc + imm_q[idx];
            end
            12: val = mdmem[ea[9:2]];
            13: begin
                wr = 1'b0;
                mdmem[ea[9:2]] = b;
            end
            default: begin
                wr      = 1'b0;
                stopped = 1'b1;
            end
        endcase
        wr = wr && (rd_q[idx] != 5'd0);
        expect_value("pc", pc, mpc);
        expect_value("wb_en", wb_en, wr);
        expect_value("halt", halt, stopped);
        expect_value("dnpc", dnpc, npc);
        if (wr) begin
            expect_value("wb_addr", wb_addr, rd_q[idx]);
            expect_value("wb_data", wb_data, val);
            mregs[rd_q[idx]] = val;
        end
        if (stopped) begin
            expect_value("a0_value", a0_value, mregs[10]);
        end else begin
            mpc = npc;
        end
    endtask

    initial begin
        bit stopped;
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'd58145;
        mpc        = reset_pc;
        stopped    = 1'b0;
        for (int r = 0; r < 32; r++) mregs[r] = '0;
        for (int w = 0; w < 256; w++) mdmem[w] = '0;
        make_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #2;
            imem_we    = 1'b1;
            imem_addr  = 8'(i);
            imem_wdata = word_q[i];
        end
        @(posedge clk);
        #2 imem_we = 1'b0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);                                // First sample sees reset_pc
        while (!stopped) begin
            check_step(stopped);
            @(negedge clk);
        end
        repeat (4) begin                               // Core stays parked on EBREAK
            expect_value("pc after halt", pc, mpc);
            expect_value("halt after halt", halt, 1);
            @(negedge clk);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = rst_n ? cycles + 1 : 0;
        if (cycles >= max_cycles) begin
            $display("timeout: core never halted");
            $display("%0d checks, %0d errors", checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

endmodule

//--- logic/cpu_top.sv
module cpu_top (
    input  logic                        clk        ,
    input  logic                        rst_n      ,
    input  logic                        imem_we    ,
    input  logic [cpu_pkg::imem_aw-1:0] imem_addr  ,
    input  logic [cpu_pkg::xlen-1:0]    imem_wdata ,
    output logic [cpu_pkg::xlen-1:0]    pc         ,
    output logic [cpu_pkg::xlen-1:0]    dnpc       ,
    output logic                        wb_en      ,
    output logic [4:0]                  wb_addr    ,
    output logic [cpu_pkg::xlen-1:0]    wb_data    ,
    output logic                        halt       ,
    output logic [cpu_pkg::xlen-1:0]    a0_value
);

    logic [cpu_pkg::xlen-1:0] inst;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [cpu_pkg::xlen-1:0] rs1_value;
    logic [cpu_pkg::xlen-1:0] rs2_value;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic [cpu_pkg::xlen-1:0] mem_rdata;
    logic [cpu_pkg::xlen-1:0] rd_value;

    ctrl_if ctrl ();

    inst_fetch u_fetch (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .imem_we    (imem_we    ),
        .imem_addr  (imem_addr  ),
        .imem_wdata (imem_wdata ),
        .dnpc       (dnpc       ),
        .halt       (halt       ),
        .pc         (pc         ),
        .inst       (inst       )
    );

    inst_decode u_decode (
        .inst (inst ),
        .rs1  (rs1  ),
        .rs2  (rs2  ),
        .rd   (rd   ),
        .halt (halt ),
        .ctrl (ctrl )
    );

    reg_file u_regs (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .rs1       (rs1       ),
        .rs2       (rs2       ),
        .rd        (rd        ),
        .rd_value  (rd_value  ),
        .rs1_value (rs1_value ),
        .rs2_value (rs2_value ),
        .a0_value  (a0_value  ),
        .ctrl      (ctrl      )
    );

    exec_unit u_exec (
        .pc         (pc         ),
        .rs1_value  (rs1_value  ),
        .rs2_value  (rs2_value  ),
        .mem_rdata  (mem_rdata  ),
        .alu_result (alu_result ),
        .rd_value   (rd_value   ),
        .dnpc       (dnpc       ),
        .ctrl       (ctrl       )
    );

    data_mem u_dmem (
        .clk   (clk        ),
        .addr  (alu_result ),
        .wdata (rs2_value  ),
        .rdata (mem_rdata  ),
        .ctrl  (ctrl       )
    );

    assign wb_en   = ctrl.reg_wen;
    assign wb_addr = rd;
    assign wb_data = rd_value;

endmodule

//--- logic/data_mem.sv
module data_mem (
    input  logic                     clk   ,
    input  logic [cpu_pkg::xlen-1:0] addr  ,
    input  logic [cpu_pkg::xlen-1:0] wdata ,
    output logic [cpu_pkg::xlen-1:0] rdata ,
    ctrl_if.mem                      ctrl
);

    logic [cpu_pkg::xlen-1:0]    mem [0:2**cpu_pkg::dmem_aw-1];
    logic [cpu_pkg::dmem_aw-1:0] word_addr;

    // Untouched words read as zero
    initial begin
        for (int i = 0; i < 2**cpu_pkg::dmem_aw; i++) begin
            mem[i] = '0;
        end
    end

    assign word_addr = addr[cpu_pkg::dmem_aw+1:2];

    always_ff @(posedge clk) begin
        if (ctrl.mem_wen) begin
            mem[word_addr] <= wdata;
        end
    end

    assign rdata = ctrl.mem_ren ? mem[word_addr] : '0;

endmodule

//--- logic/exec_unit.sv
module exec_unit (
    input  logic [cpu_pkg::xlen-1:0] pc         ,
    input  logic [cpu_pkg::xlen-1:0] rs1_value  ,
    input  logic [cpu_pkg::xlen-1:0] rs2_value  ,
    input  logic [cpu_pkg::xlen-1:0] mem_rdata  ,
    output logic [cpu_pkg::xlen-1:0] alu_result ,
    output logic [cpu_pkg::xlen-1:0] rd_value   ,
    output logic [cpu_pkg::xlen-1:0] dnpc       ,
    ctrl_if.exe                      ctrl
);

    logic [cpu_pkg::xlen-1:0] src_a;
    logic [cpu_pkg::xlen-1:0] src_b;
    logic [cpu_pkg::xlen-1:0] snpc;
    logic [cpu_pkg::xlen-1:0] target;
    logic                     taken;

    assign src_a = ctrl.src_a_pc  ? pc       : rs1_value;
    assign src_b = ctrl.src_b_imm ? ctrl.imm : rs2_value;

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::alu_add:    alu_result = src_a + src_b;
            cpu_pkg::alu_sub:    alu_result = src_a - src_b;
            cpu_pkg::alu_and:    alu_result = src_a & src_b;
            cpu_pkg::alu_or:     alu_result = src_a | src_b;
            cpu_pkg::alu_xor:    alu_result = src_a ^ src_b;
            cpu_pkg::alu_slt:    alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            cpu_pkg::alu_pass_b: alu_result = src_b;
            default:             alu_result = '0;
        endcase
    end

    assign taken  = ctrl.branch && ((rs1_value == rs2_value) ^ ctrl.branch_ne);
    assign snpc   = pc + 32'd4;
    assign target = pc + ctrl.imm;

    assign dnpc = (ctrl.jump || taken) ? target : snpc;

    // Link address for JAL, else load data or ALU
    always_comb begin
        if (ctrl.jump) begin
            rd_value = snpc;
        end else if (ctrl.mem_ren) begin
            rd_value = mem_rdata;
        end else begin
            rd_value = alu_result;
        end
    end

endmodule

//--- logic/reg_file.sv
module reg_file (
    input  logic                     clk       ,
    input  logic                     rst_n     ,
    input  logic [4:0]               rs1       ,
    input  logic [4:0]               rs2       ,
    input  logic [4:0]               rd        ,
    input  logic [cpu_pkg::xlen-1:0] rd_value  ,
    output logic [cpu_pkg::xlen-1:0] rs1_value ,
    output logic [cpu_pkg::xlen-1:0] rs2_value ,
    output logic [cpu_pkg::xlen-1:0] a0_value  ,
    ctrl_if.rf                       ctrl
);

    logic [cpu_pkg::xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_wen && rd != 5'd0) begin
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign a0_value  = regs[10];                       // Trap result

endmodule

//--- logic/inst_decode.sv
module inst_decode (
    input  logic [cpu_pkg::xlen-1:0] inst ,
    output logic [4:0]               rs1  ,
    output logic [4:0]               rs2  ,
    output logic [4:0]               rd   ,
    output logic                     halt ,
    ctrl_if.dec                      ctrl
);

    cpu_pkg::inst_u           word;
    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_s;
    logic [cpu_pkg::xlen-1:0] imm_b;
    logic [cpu_pkg::xlen-1:0] imm_u;
    logic [cpu_pkg::xlen-1:0] imm_j;
    logic                     wen_raw;

    assign word = inst;

    assign rs1  = word.r_fmt.rs1;
    assign rs2  = word.r_fmt.rs2;
    assign rd   = word.r_fmt.rd;
    assign halt = word.raw == cpu_pkg::inst_ebreak;

    assign imm_i = {{20{word.i_fmt.imm12[11]}}, word.i_fmt.imm12};
    assign imm_s = {{20{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi, word.s_fmt.imm_lo};
    assign imm_b = {{19{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi[6], word.s_fmt.imm_lo[0],
                    word.s_fmt.imm_hi[5:0], word.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_u = {word.u_fmt.imm20, 12'b0};
    assign imm_j = {{11{word.u_fmt.imm20[19]}}, word.u_fmt.imm20[19], word.u_fmt.imm20[7:0],
                    word.u_fmt.imm20[8], word.u_fmt.imm20[18:9], 1'b0};

    always_comb begin
        ctrl.alu_op    = cpu_pkg::alu_add;
        ctrl.src_a_pc  = 1'b0;
        ctrl.src_b_imm = 1'b0;
        ctrl.imm       = imm_i;
        ctrl.jump      = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.branch_ne = 1'b0;
        ctrl.mem_ren   = 1'b0;
        ctrl.mem_wen   = 1'b0;
        wen_raw        = 1'b0;
        case (word.r_fmt.opcode)
            cpu_pkg::op_rtype: begin
                wen_raw = 1'b1;
                case (word.r_fmt.funct3)
                    3'b000:  ctrl.alu_op = word.r_fmt.funct7[5] ? cpu_pkg::alu_sub
                                                                : cpu_pkg::alu_add;
                    3'b111:  ctrl.alu_op = cpu_pkg::alu_and;
                    3'b110:  ctrl.alu_op = cpu_pkg::alu_or;
                    3'b100:  ctrl.alu_op = cpu_pkg::alu_xor;
                    3'b010:  ctrl.alu_op = cpu_pkg::alu_slt;
                    default: wen_raw     = 1'b0;       // Shifts and sltu unsupported
                endcase
            end
            cpu_pkg::op_itype: begin
                ctrl.src_b_imm = 1'b1;
                wen_raw        = word.i_fmt.funct3 == 3'b000;   // ADDI only
            end
            cpu_pkg::op_lui: begin
                ctrl.alu_op    = cpu_pkg::alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm       = imm_u;
                wen_raw        = 1'b1;
            end
            cpu_pkg::op_auipc: begin
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm       = imm_u;
                wen_raw        = 1'b1;
            end
            cpu_pkg::op_jal: begin
                ctrl.imm  = imm_j;
                ctrl.jump = 1'b1;
                wen_raw   = 1'b1;
            end
            cpu_pkg::op_branch: begin
                ctrl.imm       = imm_b;
                ctrl.branch    = word.s_fmt.funct3[2:1] == 2'b00;   // BEQ and BNE
                ctrl.branch_ne = word.s_fmt.funct3[0];
            end
            cpu_pkg::op_load: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_ren   = word.i_fmt.funct3 == 3'b010;
                wen_raw        = ctrl.mem_ren;
            end
            cpu_pkg::op_store: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.imm       = imm_s;
                ctrl.mem_wen   = word.s_fmt.funct3 == 3'b010;
            end
            default: ;                                 // EBREAK and unknown opcodes
        endcase
    end

    assign ctrl.reg_wen = wen_raw && (rd != 5'd0);

endmodule

//--- logic/inst_fetch.sv
module inst_fetch (
    input  logic                        clk        ,
    input  logic                        rst_n      ,
    input  logic                        imem_we    ,
    input  logic [cpu_pkg::imem_aw-1:0] imem_addr  ,
    input  logic [cpu_pkg::xlen-1:0]    imem_wdata ,
    input  logic [cpu_pkg::xlen-1:0]    dnpc       ,
    input  logic                        halt       ,
    output logic [cpu_pkg::xlen-1:0]    pc         ,
    output logic [cpu_pkg::xlen-1:0]    inst
);

    logic [cpu_pkg::xlen-1:0] imem [0:2**cpu_pkg::imem_aw-1];

    // Load port stays open during reset
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign inst = imem[pc[cpu_pkg::imem_aw+1:2]];           // Upper address bits ignored

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= cpu_pkg::reset_pc;
        end else if (!halt) begin
            pc <= dnpc;
        end
    end

    // Every jump and branch target from execute must keep the PC on a word
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

//--- logic/ctrl_if.sv
interface ctrl_if;

    logic [2:0]              alu_op;
    logic                    src_a_pc;                 // Operand A is the PC
    logic                    src_b_imm;                // Operand B is the immediate
    logic [cpu_pkg::xlen-1:0] imm;
    logic                    jump;
    logic                    branch;
    logic                    branch_ne;
    logic                    mem_ren;
    logic                    mem_wen;
    logic                    reg_wen;

    modport dec (
        output alu_op, src_a_pc, src_b_imm, imm, jump, branch, branch_ne,
               mem_ren, mem_wen, reg_wen
    );

    modport exe (
        input alu_op, src_a_pc, src_b_imm, imm, jump, branch, branch_ne, mem_ren
    );

    modport mem (input mem_ren, mem_wen);

    modport rf (input reg_wen);

endinterface

//--- logic/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen    = 32;
    localparam int imem_aw = 8;                        // 256 words
    localparam int dmem_aw = 8;                        // 256 words

    localparam logic [xlen-1:0] reset_pc    = 32'h8000_0000;
    localparam logic [xlen-1:0] inst_ebreak = 32'h0010_0073;

    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] alu_add    = 3'd0;
    localparam logic [2:0] alu_sub    = 3'd1;
    localparam logic [2:0] alu_and    = 3'd2;
    localparam logic [2:0] alu_or     = 3'd3;
    localparam logic [2:0] alu_xor    = 3'd4;
    localparam logic [2:0] alu_slt    = 3'd5;
    localparam logic [2:0] alu_pass_b = 3'd6;

    // B-type shares the S layout, J-type shares the U layout
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } inst_u;

endpackage
